// File: source/rename_pkg.sv
/* Register rename shared definitions
 * Register counts, checkpoint depth and the vector types that the free
 * list, the rename map table and the rename top level have in common
 */

package rename_pkg;

    // Register file sizes
    localparam int NUM_ISA_REGS     = 32;                           // x0..x31
    localparam int NUM_PHYS_REGS    = 64;                           // Physical register file
    localparam int NUM_CHECKPOINTS  = 4;                            // Current version + 3 snapshots
    localparam int NUM_FREE_ENTRIES = NUM_PHYS_REGS - NUM_ISA_REGS; // Free list capacity

    // Field widths derived from the sizes above
    localparam int AREG_W     = $clog2(NUM_ISA_REGS);
    localparam int PHREG_W    = $clog2(NUM_PHYS_REGS);
    localparam int CKPT_W     = $clog2(NUM_CHECKPOINTS);
    localparam int FREE_PTR_W = $clog2(NUM_FREE_ENTRIES);
    localparam int FREE_CNT_W = $clog2(NUM_FREE_ENTRIES + 1);       // Must hold a full list
    localparam int CKPT_CNT_W = CKPT_W + 1;

    // Architectural register number
    typedef logic [AREG_W-1:0]     areg_t;

    // Physical register number
    typedef logic [PHREG_W-1:0]    phreg_t;

    // Checkpoint label, wraps around the version ring
    typedef logic [CKPT_W-1:0]     checkpoint_t;

    // Slot index inside one free list version
    typedef logic [FREE_PTR_W-1:0] free_ptr_t;

    // Occupancy of one free list version, 0 to full
    typedef logic [FREE_CNT_W-1:0] free_cnt_t;

    // Number of live checkpoints beside the current version
    typedef logic [CKPT_CNT_W-1:0] ckpt_cnt_t;

endpackage

// File: source/free_list.sv
/* Checkpointed free list
 * Circular buffer of free physical registers, kept in one copy per version.
 * Allocation pops the current version, frees go to the current version and
 * to every live snapshot, so a recovery never loses a committed free
 */

`timescale 1ns/1ps

module free_list (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    alloc_i,             // Pop one register from the head
    input  logic                    free_i,              // Push a committed free
    input  rename_pkg::phreg_t      free_preg_i,         // Register being returned
    input  logic                    checkpoint_i,        // Snapshot after this cycle's update
    input  logic                    recover_i,           // Roll back to recover_label_i
    input  rename_pkg::checkpoint_t recover_label_i,
    input  logic                    delete_checkpoint_i, // Oldest branch resolved
    output rename_pkg::phreg_t      new_preg_o,          // Allocated register, 0 if none
    output rename_pkg::checkpoint_t checkpoint_label_o,  // Label a snapshot would get
    output logic                    empty_o,
    output logic                    out_of_checkpoints_o
);

    // Slot storage and per-version pointers
    rename_pkg::phreg_t      slots [rename_pkg::NUM_CHECKPOINTS][rename_pkg::NUM_FREE_ENTRIES];
    rename_pkg::free_ptr_t   head  [rename_pkg::NUM_CHECKPOINTS];
    rename_pkg::free_ptr_t   tail  [rename_pkg::NUM_CHECKPOINTS];
    rename_pkg::free_cnt_t   count [rename_pkg::NUM_CHECKPOINTS];

    // Next-state pointers, before any snapshot copy
    rename_pkg::free_ptr_t   head_nxt  [rename_pkg::NUM_CHECKPOINTS];
    rename_pkg::free_ptr_t   tail_nxt  [rename_pkg::NUM_CHECKPOINTS];
    rename_pkg::free_cnt_t   count_nxt [rename_pkg::NUM_CHECKPOINTS];

    // Version ring
    rename_pkg::checkpoint_t version_head;   // Current version
    rename_pkg::checkpoint_t version_tail;   // Oldest live snapshot
    rename_pkg::checkpoint_t ckpt_slot;      // Where the next current version goes
    rename_pkg::checkpoint_t push_limit;     // Newest version that takes a free
    rename_pkg::checkpoint_t tail_after;     // version_tail after a delete
    rename_pkg::ckpt_cnt_t   live_cnt;

    logic [rename_pkg::NUM_CHECKPOINTS-1:0] push;
    logic bypass;
    logic pop;

    // Distance from one label to another going forward around the ring
    function automatic rename_pkg::checkpoint_t ring_dist(input rename_pkg::checkpoint_t from,
                                                          input rename_pkg::checkpoint_t to);
        return to - from;
    endfunction

    assign ckpt_slot  = version_head + rename_pkg::checkpoint_t'(1);
    assign tail_after = version_tail + rename_pkg::checkpoint_t'(delete_checkpoint_i);
    assign push_limit = recover_i ? recover_label_i : version_head;   // Recovered version is current

    assign empty_o = (count[version_head] == '0);
    assign bypass  = alloc_i & free_i & empty_o;    // Freed register handed straight out
    assign pop     = alloc_i & ~empty_o;

    // Per-version push and pointer updates
    always_comb begin
        rename_pkg::checkpoint_t v_lbl;
        logic                    pop_here;
        for (int v = 0; v < rename_pkg::NUM_CHECKPOINTS; v++) begin
            v_lbl    = rename_pkg::checkpoint_t'(v);
            pop_here = pop & (v_lbl == version_head);
            // Live window is version_tail up to and including push_limit
            push[v]  = free_i
                     & (ring_dist(version_tail, v_lbl) <= ring_dist(version_tail, push_limit))
                     & (count[v] < rename_pkg::free_cnt_t'(rename_pkg::NUM_FREE_ENTRIES))
                     & ~(bypass & (v_lbl == version_head));   // Already consumed by the bypass
            head_nxt[v]  = head[v] + rename_pkg::free_ptr_t'(pop_here);
            tail_nxt[v]  = tail[v] + rename_pkg::free_ptr_t'(push[v]);
            count_nxt[v] = count[v] + rename_pkg::free_cnt_t'(push[v])
                         - rename_pkg::free_cnt_t'(pop_here);
        end
    end

    // Pointers, counts and the version ring
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_head <= '0;
            version_tail <= '0;
            live_cnt     <= '0;
            for (int v = 0; v < rename_pkg::NUM_CHECKPOINTS; v++) begin
                head[v]  <= '0;
                tail[v]  <= '0;   // Full list, tail wraps onto head
                count[v] <= (v == 0) ? rename_pkg::free_cnt_t'(rename_pkg::NUM_FREE_ENTRIES)
                                     : '0;
            end
        end else begin
            for (int v = 0; v < rename_pkg::NUM_CHECKPOINTS; v++) begin
                if (checkpoint_i && (rename_pkg::checkpoint_t'(v) == ckpt_slot)) begin
                    // New current version starts from the updated state
                    head[v]  <= head_nxt[version_head];
                    tail[v]  <= tail_nxt[version_head];
                    count[v] <= count_nxt[version_head];
                end else begin
                    head[v]  <= head_nxt[v];
                    tail[v]  <= tail_nxt[v];
                    count[v] <= count_nxt[v];
                end
            end

            version_tail <= tail_after;

            if (recover_i) begin
                version_head <= recover_label_i;
                // Snapshots older than the label stay live
                live_cnt     <= rename_pkg::ckpt_cnt_t'(ring_dist(tail_after, recover_label_i));
            end else begin
                version_head <= version_head + rename_pkg::checkpoint_t'(checkpoint_i);
                live_cnt     <= live_cnt + rename_pkg::ckpt_cnt_t'(checkpoint_i)
                              - rename_pkg::ckpt_cnt_t'(delete_checkpoint_i);
            end
        end
    end

    // Slot contents, every version starts from the same ordered list
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int v = 0; v < rename_pkg::NUM_CHECKPOINTS; v++) begin
                for (int k = 0; k < rename_pkg::NUM_FREE_ENTRIES; k++) begin
                    slots[v][k] <= rename_pkg::phreg_t'(rename_pkg::NUM_ISA_REGS + k);
                end
            end
        end else begin
            for (int v = 0; v < rename_pkg::NUM_CHECKPOINTS; v++) begin
                for (int k = 0; k < rename_pkg::NUM_FREE_ENTRIES; k++) begin
                    if (checkpoint_i && (rename_pkg::checkpoint_t'(v) == ckpt_slot)) begin
                        // Copy current slots including this cycle's push
                        slots[v][k] <= (push[version_head]
                                        && (rename_pkg::free_ptr_t'(k) == tail[version_head]))
                                     ? free_preg_i : slots[version_head][k];
                    end else if (push[v] && (rename_pkg::free_ptr_t'(k) == tail[v])) begin
                        slots[v][k] <= free_preg_i;
                    end
                end
            end
        end
    end

    assign new_preg_o = !alloc_i ? '0
                      : bypass   ? free_preg_i
                      : slots[version_head][head[version_head]];

    assign checkpoint_label_o   = version_head;   // Current version freezes as the snapshot
    assign out_of_checkpoints_o = (live_cnt ==
                                   rename_pkg::ckpt_cnt_t'(rename_pkg::NUM_CHECKPOINTS - 1));

endmodule

// File: source/rename_table.sv
/* Checkpointed rename map table
 * Maps architectural registers to physical registers, one map per version.
 * Lookups of the current map are combinational and see the map from before
 * this cycle's write; a checkpoint freezes the current map after the write
 */

`timescale 1ns/1ps

module rename_table (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  rename_pkg::areg_t       src1_i,
    input  rename_pkg::areg_t       src2_i,
    input  rename_pkg::areg_t       dst_i,
    input  logic                    write_i,             // Map dst_i to new_preg_i
    input  rename_pkg::phreg_t      new_preg_i,
    input  logic                    checkpoint_i,
    input  logic                    recover_i,
    input  rename_pkg::checkpoint_t recover_label_i,
    input  logic                    delete_checkpoint_i,
    output rename_pkg::phreg_t      phys_src1_o,
    output rename_pkg::phreg_t      phys_src2_o,
    output rename_pkg::phreg_t      old_preg_o           // Mapping that dst_i replaces
);

    // One full map per version
    rename_pkg::phreg_t      map [rename_pkg::NUM_CHECKPOINTS][rename_pkg::NUM_ISA_REGS];

    rename_pkg::checkpoint_t version_head;   // Current map
    rename_pkg::checkpoint_t version_tail;   // Oldest live snapshot
    rename_pkg::checkpoint_t ckpt_slot;
    rename_pkg::checkpoint_t tail_after;
    rename_pkg::ckpt_cnt_t   live_cnt;
    logic                    take_ckpt;

    assign ckpt_slot  = version_head + rename_pkg::checkpoint_t'(1);
    assign tail_after = version_tail + rename_pkg::checkpoint_t'(delete_checkpoint_i);

    // Never overwrite the oldest live snapshot
    assign take_ckpt = checkpoint_i
                     & (live_cnt != rename_pkg::ckpt_cnt_t'(rename_pkg::NUM_CHECKPOINTS - 1));

    // Version ring, kept in step with the free list
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_head <= '0;
            version_tail <= '0;
            live_cnt     <= '0;
        end else begin
            version_tail <= tail_after;
            if (recover_i) begin
                version_head <= recover_label_i;
                live_cnt     <= rename_pkg::ckpt_cnt_t'(
                                    rename_pkg::checkpoint_t'(recover_label_i - tail_after));
            end else begin
                version_head <= version_head + rename_pkg::checkpoint_t'(take_ckpt);
                live_cnt     <= live_cnt + rename_pkg::ckpt_cnt_t'(take_ckpt)
                              - rename_pkg::ckpt_cnt_t'(delete_checkpoint_i);
            end
        end
    end

    // Map storage, identity after reset in every version
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int v = 0; v < rename_pkg::NUM_CHECKPOINTS; v++) begin
                for (int r = 0; r < rename_pkg::NUM_ISA_REGS; r++) begin
                    map[v][r] <= rename_pkg::phreg_t'(r);
                end
            end
        end else begin
            for (int v = 0; v < rename_pkg::NUM_CHECKPOINTS; v++) begin
                // x0 stays on physical 0, loop starts at 1
                for (int r = 1; r < rename_pkg::NUM_ISA_REGS; r++) begin
                    if (take_ckpt && !recover_i
                        && (rename_pkg::checkpoint_t'(v) == ckpt_slot)) begin
                        // Next current map carries this cycle's write
                        map[v][r] <= (write_i && (rename_pkg::areg_t'(r) == dst_i))
                                   ? new_preg_i : map[version_head][r];
                    end else if (write_i && (rename_pkg::checkpoint_t'(v) == version_head)
                                 && (rename_pkg::areg_t'(r) == dst_i)) begin
                        map[v][r] <= new_preg_i;
                    end
                end
            end
        end
    end

    // Sources precede the instruction's own destination
    assign phys_src1_o = map[version_head][src1_i];
    assign phys_src2_o = map[version_head][src2_i];
    assign old_preg_o  = map[version_head][dst_i];   // Freed when this instruction commits

endmodule

// File: source/rename_unit.sv
/* Register rename stage
 * Renames one instruction per cycle onto the physical register file.
 * Joins the free list and the map table, forms the allocation request
 * and holds back renames and checkpoints that cannot be accepted
 */

`timescale 1ns/1ps

module rename_unit (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    rename_i,            // Rename one instruction
    input  rename_pkg::areg_t       src1_i,
    input  rename_pkg::areg_t       src2_i,
    input  rename_pkg::areg_t       dst_i,
    input  logic                    dst_we_i,            // Instruction writes dst_i
    input  logic                    commit_free_i,       // Return commit_preg_i to the list
    input  rename_pkg::phreg_t      commit_preg_i,
    input  logic                    checkpoint_i,        // Branch takes a checkpoint
    input  logic                    recover_i,           // Mispredict
    input  rename_pkg::checkpoint_t recover_label_i,
    input  logic                    delete_checkpoint_i, // Oldest branch resolved
    output rename_pkg::phreg_t      phys_src1_o,
    output rename_pkg::phreg_t      phys_src2_o,
    output rename_pkg::phreg_t      new_preg_o,
    output rename_pkg::phreg_t      old_preg_o,
    output rename_pkg::checkpoint_t checkpoint_label_o,
    output logic                    stall_o,             // Hold and retry the rename
    output logic                    out_of_checkpoints_o
);

    logic               rename_eff;   // Recovery squashes the rename
    logic               alloc_want;
    logic               alloc_req;
    logic               ckpt_take;
    logic               fl_empty;
    logic               fl_out_of_ckpt;
    rename_pkg::phreg_t new_preg;

    assign rename_eff = rename_i & ~recover_i;
    assign alloc_want = rename_eff & dst_we_i & (dst_i != '0);   // x0 never allocates

    // Empty list stalls unless a free arrives this cycle for the bypass
    assign stall_o    = alloc_want & fl_empty & ~commit_free_i;
    assign alloc_req  = alloc_want & ~stall_o;

    // Stalled instruction retries with its checkpoint
    assign ckpt_take  = checkpoint_i & ~fl_out_of_ckpt & ~recover_i & ~stall_o;

    free_list u_free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .alloc_i              (alloc_req),
        .free_i               (commit_free_i),
        .free_preg_i          (commit_preg_i),
        .checkpoint_i         (ckpt_take),
        .recover_i            (recover_i),
        .recover_label_i      (recover_label_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .new_preg_o           (new_preg),
        .checkpoint_label_o   (checkpoint_label_o),
        .empty_o              (fl_empty),
        .out_of_checkpoints_o (fl_out_of_ckpt)
    );

    rename_table u_rename_table (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .src1_i              (src1_i),
        .src2_i              (src2_i),
        .dst_i               (dst_i),
        .write_i             (alloc_req),
        .new_preg_i          (new_preg),
        .checkpoint_i        (ckpt_take),
        .recover_i           (recover_i),
        .recover_label_i     (recover_label_i),
        .delete_checkpoint_i (delete_checkpoint_i),
        .phys_src1_o         (phys_src1_o),
        .phys_src2_o         (phys_src2_o),
        .old_preg_o          (old_preg_o)
    );

    assign new_preg_o           = new_preg;         // 0 when nothing allocates
    assign out_of_checkpoints_o = fl_out_of_ckpt;

endmodule

// File: dv/tb_rename_unit.sv
/* Testbench for the register rename stage
 * Drives rename, commit, checkpoint and recovery strobes from an LFSR and
 * from directed sequences, and checks every output against a model of the
 * map and free list versions kept here
 */

`timescale 1ns/1ps

module tb_rename_unit;

    localparam int RANDOM_CYCLES   = 2000;
    localparam int DIRECTED_CYCLES = 400;   // Upper bound for the directed tests
    localparam int MAX_CYCLES      = RANDOM_CYCLES + DIRECTED_CYCLES + 600;
    localparam int NV              = rename_pkg::NUM_CHECKPOINTS;
    localparam int NFREE           = rename_pkg::NUM_FREE_ENTRIES;

    logic                    clk_i;
    logic                    rstn_i;
    logic                    rename_i;
    rename_pkg::areg_t       src1_i;
    rename_pkg::areg_t       src2_i;
    rename_pkg::areg_t       dst_i;
    logic                    dst_we_i;
    logic                    commit_free_i;
    rename_pkg::phreg_t      commit_preg_i;
    logic                    checkpoint_i;
    logic                    recover_i;
    rename_pkg::checkpoint_t recover_label_i;
    logic                    delete_checkpoint_i;
    rename_pkg::phreg_t      phys_src1_o;
    rename_pkg::phreg_t      phys_src2_o;
    rename_pkg::phreg_t      new_preg_o;
    rename_pkg::phreg_t      old_preg_o;
    rename_pkg::checkpoint_t checkpoint_label_o;
    logic                    stall_o;
    logic                    out_of_checkpoints_o;

    // Model state, one map and one free list per version
    rename_pkg::phreg_t m_map [NV][rename_pkg::NUM_ISA_REGS];
    rename_pkg::phreg_t m_fl  [NV][NFREE];   // Entry 0 is the next to allocate
    int                 m_len [NV];
    int                 m_vh;                // Current version
    int                 m_vt;                // Oldest live snapshot
    int                 m_live;
    rename_pkg::phreg_t pending [$];         // Old mappings waiting to be freed

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;

    rename_unit i_dut (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .rename_i             (rename_i),
        .src1_i               (src1_i),
        .src2_i               (src2_i),
        .dst_i                (dst_i),
        .dst_we_i             (dst_we_i),
        .commit_free_i        (commit_free_i),
        .commit_preg_i        (commit_preg_i),
        .checkpoint_i         (checkpoint_i),
        .recover_i            (recover_i),
        .recover_label_i      (recover_label_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .phys_src1_o          (phys_src1_o),
        .phys_src2_o          (phys_src2_o),
        .new_preg_o           (new_preg_o),
        .old_preg_o           (old_preg_o),
        .checkpoint_label_o   (checkpoint_label_o),
        .stall_o              (stall_o),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 16'hB400;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int v = 0; v < NV; v++) begin
            for (int r = 0; r < rename_pkg::NUM_ISA_REGS; r++) begin
                m_map[v][r] = rename_pkg::phreg_t'(r);   // Identity map
            end
            m_len[v] = 0;
        end
        for (int k = 0; k < NFREE; k++) begin
            m_fl[0][k] = rename_pkg::phreg_t'(rename_pkg::NUM_ISA_REGS + k);
        end
        m_len[0] = NFREE;
        m_vh     = 0;
        m_vt     = 0;
        m_live   = 0;
        pending.delete();
    endtask

    task automatic drive_inputs(input logic ren, input int s1, input int s2, input int d,
                                input logic we, input logic cf, input int cp, input logic ck,
                                input logic rc, input int lbl, input logic del);
        rename_i            <= ren;
        src1_i              <= rename_pkg::areg_t'(s1);
        src2_i              <= rename_pkg::areg_t'(s2);
        dst_i               <= rename_pkg::areg_t'(d);
        dst_we_i            <= we;
        commit_free_i       <= cf;
        commit_preg_i       <= rename_pkg::phreg_t'(cp);
        checkpoint_i        <= ck;
        recover_i           <= rc;
        recover_label_i     <= rename_pkg::checkpoint_t'(lbl);
        delete_checkpoint_i <= del;
    endtask

    // Compare this cycle's outputs, then advance the model to the next edge
    task automatic check_and_update();
        int                 cur;
        int                 limit;
        int                 v;
        int                 nxt;
        int                 vt_after;
        logic               want;
        logic               empty;
        logic               stall;
        logic               alloc;
        logic               bypass;
        logic               ooc;
        logic               ck;
        logic [NV-1:0]      push;
        rename_pkg::phreg_t exp_new;
        rename_pkg::phreg_t exp_old;
        cur     = m_vh;
        empty   = (m_len[cur] == 0);
        want    = rename_i && !recover_i && dst_we_i && (dst_i != 0);   // x0 never allocates
        stall   = want && empty && !commit_free_i;
        alloc   = want && !stall;
        bypass  = alloc && empty;                                       // Free handed straight on
        ooc     = (m_live == NV - 1);
        ck      = checkpoint_i && !ooc && !recover_i && !stall;
        exp_new = !alloc ? '0 : (bypass ? commit_preg_i : m_fl[cur][0]);
        exp_old = m_map[cur][dst_i];

        check_val("phys_src1_o", 8'(phys_src1_o), 8'(m_map[cur][src1_i]));
        check_val("phys_src2_o", 8'(phys_src2_o), 8'(m_map[cur][src2_i]));
        check_val("new_preg_o", 8'(new_preg_o), 8'(exp_new));
        check_val("old_preg_o", 8'(old_preg_o), 8'(exp_old));
        check_val("checkpoint_label_o", 8'(checkpoint_label_o), 8'(cur));
        check_val("stall_o", 8'(stall_o), 8'(stall));
        check_val("out_of_checkpoints_o", 8'(out_of_checkpoints_o), 8'(ooc));

        // A free reaches every live version up to the one that stays current
        limit = recover_i ? int'(recover_label_i) : cur;
        push  = '0;
        for (int k = 0; k < NV; k++) begin
            v       = (m_vt + k) % NV;
            push[v] = commit_free_i && (k <= (limit - m_vt + NV) % NV)
                    && (m_len[v] < NFREE) && !(bypass && v == cur);
        end

        if (alloc && !bypass) begin
            for (int k = 0; k < m_len[cur] - 1; k++) begin
                m_fl[cur][k] = m_fl[cur][k+1];
            end
            m_len[cur]--;
        end
        if (alloc) begin
            m_map[cur][dst_i] = exp_new;
            pending.push_back(exp_old);   // Freed once this instruction commits
        end
        for (int w = 0; w < NV; w++) begin
            if (push[w]) begin
                m_fl[w][m_len[w]] = commit_preg_i;
                m_len[w]++;
            end
        end

        // Snapshot holds the state after this cycle's rename and free
        if (ck) begin
            nxt = (cur + 1) % NV;
            m_map[nxt] = m_map[cur];
            for (int k = 0; k < NFREE; k++) begin
                m_fl[nxt][k] = m_fl[cur][k];
            end
            m_len[nxt] = m_len[cur];
            m_vh       = nxt;
        end

        vt_after = (m_vt + int'(delete_checkpoint_i)) % NV;
        if (recover_i) begin
            m_vh   = int'(recover_label_i);
            m_live = (m_vh - vt_after + NV) % NV;   // Older snapshots survive
        end else begin
            m_live = m_live + int'(ck) - int'(delete_checkpoint_i);
        end
        m_vt = vt_after;
    endtask

    task automatic apply_cycle(input logic ren, input int s1, input int s2, input int d,
                               input logic we, input logic cf, input int cp, input logic ck,
                               input logic rc, input int lbl, input logic del);
        @(posedge clk_i);
        drive_inputs(ren, s1, s2, d, we, cf, cp, ck, rc, lbl, del);
        @(negedge clk_i);   // Outputs settled, inputs held
        check_and_update();
    endtask

    task automatic reset_dut();
        @(posedge clk_i);
        rstn_i <= 1'b0;
        drive_inputs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        reset_model();
    endtask

    task automatic rename_cycle(input int d, input logic ck);
        apply_cycle(1, d, 31 - d, d, 1, 0, 0, ck, 0, 0, 0);
    endtask

    task automatic free_cycle(input logic ren, input int d);
        int cp;
        cp = int'(pending.pop_front());
        apply_cycle(ren, d, 0, d, 1, 1, cp, 0, 0, 0, 0);
    endtask

    // Read out the whole current map, two registers per cycle
    task automatic sweep_map();
        for (int i = 0; i < rename_pkg::NUM_ISA_REGS / 2; i++) begin
            apply_cycle(0, 2 * i, 2 * i + 1, 0, 0, 0, 0, 0, 0, 0, 0);
        end
    endtask

    task automatic random_cycle();
        logic ren;
        logic we;
        logic cf;
        logic ck;
        logic rc;
        logic del;
        int   s1;
        int   s2;
        int   d;
        int   cp;
        int   lbl;
        ren = (rand_bits(2) != 0);
        s1  = int'(rand_bits(5));
        s2  = int'(rand_bits(5));
        d   = int'(rand_bits(5));
        we  = (rand_bits(3) != 0);
        cf  = 1'b0;
        cp  = 0;
        if (pending.size() > 0 && rand_bits(3) < 5) begin
            cf = 1'b1;
            cp = int'(pending.pop_front());
        end
        ck  = (rand_bits(3) == 0);
        rc  = 1'b0;
        lbl = 0;
        if (m_live > 0 && rand_bits(4) == 0) begin
            rc  = 1'b1;
            lbl = (m_vt + int'(rand_bits(2)) % m_live) % NV;   // Any live snapshot
        end
        del = !rc && m_live > 0 && (rand_bits(4) == 0);
        apply_cycle(ren, s1, s2, d, we, cf, cp, ck, rc, lbl, del);
    endtask

    initial begin
        int n;
        int lbl;
        int cp;
        lfsr   = 16'd93;
        errors = 0;
        checks = 0;
        rstn_i = 1'b0;
        rename_i            = 1'b0;
        src1_i              = '0;
        src2_i              = '0;
        dst_i               = '0;
        dst_we_i            = 1'b0;
        commit_free_i       = 1'b0;
        commit_preg_i       = '0;
        checkpoint_i        = 1'b0;
        recover_i           = 1'b0;
        recover_label_i     = '0;
        delete_checkpoint_i = 1'b0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        reset_model();

        // Identity map and in-order allocation from 32
        for (int k = 0; k < 3; k++) begin
            rename_cycle(k + 1, 0);
            check_val("first allocations", 8'(new_preg_o), 8'(32 + k));
        end
        rename_cycle(1, 0);   // Old mapping of x1 is 32
        apply_cycle(1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);   // x0 write
        sweep_map();

        // Drain the list until the rename stalls
        n = 0;
        while (stall_o !== 1'b1 && n < 40) begin
            rename_cycle(1 + n % 31, 0);
            n++;
        end
        if (stall_o !== 1'b1) begin
            errors++;
            $display("Error at %0t: stall_o never rose while draining the free list", $time);
        end
        repeat (3) rename_cycle(5, 0);   // Held stall changes nothing
        sweep_map();
        cp = int'(pending[0]);
        free_cycle(1, 7);   // Empty list, freed register bypassed
        check_val("bypass new_preg_o", 8'(new_preg_o), 8'(cp));

        // Frees come back in FIFO order
        repeat (3) free_cycle(0, 0);
        free_cycle(1, 9);
        repeat (4) rename_cycle(11, 0);

        // Checkpoint ring fills at three live snapshots
        reset_dut();
        for (int k = 0; k < 3; k++) begin
            rename_cycle(k + 1, 1);
        end
        rename_cycle(4, 1);   // Ignored while out of checkpoints
        check_val("out_of_checkpoints_o", 8'(out_of_checkpoints_o), 8'd1);
        apply_cycle(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
        rename_cycle(6, 1);   // Accepted again
        while (m_live > 0) begin
            apply_cycle(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
        end

        // Recover restores the snapshot, branch allocation and later frees included
        lbl = m_vh;
        free_cycle(1, 12);
        apply_cycle(1, 3, 4, 13, 1, 0, 0, 1, 0, 0, 0);
        for (int k = 0; k < 20; k++) begin
            if (k % 3 == 0 && pending.size() > 0) begin
                free_cycle(1, 14 + k % 10);
            end else begin
                rename_cycle(14 + k % 10, 0);
            end
        end
        apply_cycle(0, 0, 0, 0, 0, 0, 0, 0, 1, lbl, 0);
        sweep_map();
        repeat (8) rename_cycle(20, 0);

        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            random_cycle();
        end

        @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: filelist.f
source/rename_pkg.sv
source/free_list.sv
source/rename_table.sv
source/rename_unit.sv
dv/tb_rename_unit.sv

// File: Makefile
# Verilator build and run of the rename stage testbench

TOP = tb_rename_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
